// File: verilog/cache_axi_pkg.sv
// cache_axi bridge definitions
// widths, beat counts and the opcode and size encodings of both ports
package cache_axi_pkg;

  localparam int LINE_W     = 512;
  localparam int BEAT_W     = 64;
  localparam int ADDR_W     = 64;
  localparam int BEATS      = 8;              // beats per line
  localparam int LINE_BYTES = 64;             // address step between lines
  localparam int BEAT_CNT_W = $clog2(BEATS);

  // axi_io blks field carries beats minus one
  localparam logic [7:0] BLKS = 8'(BEATS - 1);

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_DWORD = 2'd3   // only size driven by the bridge
  } io_size_e;

endpackage

// File: verilog/line_test_pkg.sv
// line exerciser definitions
// state encoding, idle delay, start address and data pattern LFSR
package line_test_pkg;

  typedef enum logic [1:0] {
    ST_WAIT_WR = 2'd0,
    ST_WRITE   = 2'd1,
    ST_WAIT_RD = 2'd2,
    ST_READ    = 2'd3
  } test_state_e;

  localparam int IDLE_CYCLES = 20;          // gap between requests
  localparam int IDLE_CNT_W  = $clog2(IDLE_CYCLES + 1);

  localparam logic [63:0] START_ADDR = 64'h0000_0000_8000_0000;

  // galois lfsr for write patterns, x^64 + x^63 + x^61 + x^60 + 1
  localparam logic [63:0] PATTERN_SEED = 64'h1d8b_9dca_096d_5801;
  localparam logic [63:0] LFSR_TAPS    = 64'hd800_0000_0000_0000;

endpackage

// File: verilog/axi_write_serializer.sv
// write serializer
// holds one cache line and hands it out one 64-bit beat at a time
`timescale 1ns/1ps

module axi_write_serializer import cache_axi_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_load,
  input  logic [LINE_W-1:0] i_line,
  input  logic              i_beat_taken,
  output logic [BEAT_W-1:0] o_beat,
  output logic              o_done
);

  logic [LINE_W-1:0]     line_q;
  logic [BEAT_CNT_W-1:0] beat_cnt;
  logic                  active;     // line loaded, beats still owed

  assign o_beat = line_q[BEAT_W-1:0];
  assign o_done = i_beat_taken && (beat_cnt == BEAT_CNT_W'(BEATS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
      active   <= 1'b0;
    end else if (i_load) begin
      beat_cnt <= '0;
      active   <= 1'b1;
    end else if (i_beat_taken) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (o_done) active <= 1'b0;   // last beat gone
    end
  end

  // payload shifts down so the next beat sits in the low bits
  always_ff @(posedge clk) begin
    if (i_load) begin
      line_q <= i_line;
    end else if (i_beat_taken) begin
      line_q <= {{BEAT_W{1'b0}}, line_q[LINE_W-1:BEAT_W]};
    end
  end

  // no beat may be taken between the final beat and the next load
  a_no_beat_after_done: assert property (
    @(posedge clk) disable iff (rst)
    i_beat_taken |-> active
  );

endmodule

// File: verilog/axi_read_assembler.sv
// read assembler
// gathers eight returned beats into one cache line, beat 0 lowest
`timescale 1ns/1ps

module axi_read_assembler import cache_axi_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  input  logic              i_beat_valid,
  input  logic [BEAT_W-1:0] i_beat,
  output logic [LINE_W-1:0] o_line,
  output logic              o_done
);

  logic [LINE_W-1:0]     line_q;
  logic [BEAT_CNT_W-1:0] beat_cnt;

  assign o_line = line_q;
  assign o_done = i_beat_valid && (beat_cnt == BEAT_CNT_W'(BEATS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (i_start) begin
      beat_cnt <= '0;
    end else if (i_beat_valid) begin
      beat_cnt <= beat_cnt + 1'b1;   // wraps to 0 after the eighth beat
    end
  end

  // new beat enters at the top, earlier beats move toward bit 0
  always_ff @(posedge clk) begin
    if (i_beat_valid) begin
      line_q <= {i_beat, line_q[LINE_W-1:BEAT_W]};
    end
  end

  // after a start, exactly eight beats arrive before the next start
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    i_start |-> (beat_cnt == '0) && !i_beat_valid
  );

endmodule

// File: verilog/cache_axi.sv
// cache_axi bridge controller
// turns one line request into an eight-beat axi_io burst and acks it
`timescale 1ns/1ps

module cache_axi import cache_axi_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cache_axi_req,
  input  req_op_e           i_cache_axi_op,
  input  logic [ADDR_W-1:0] i_cache_axi_addr,
  input  logic [LINE_W-1:0] i_cache_axi_wdata,
  output logic              o_cache_axi_ack,
  output logic [LINE_W-1:0] o_cache_axi_rdata,
  input  logic              i_axi_io_ready,
  input  logic [BEAT_W-1:0] i_axi_io_rdata,
  output logic              o_axi_io_valid,
  output req_op_e           o_axi_io_op,
  output logic [ADDR_W-1:0] o_axi_io_addr,
  output io_size_e          o_axi_io_size,
  output logic [7:0]        o_axi_io_blks,
  output logic [BEAT_W-1:0] o_axi_io_wdata
);

  typedef enum logic [1:0] {
    BR_IDLE  = 2'd0,
    BR_BURST = 2'd1,
    BR_ACK   = 2'd2
  } br_state_e;

  br_state_e         state;
  req_op_e           op_q;
  logic [ADDR_W-1:0] addr_q;

  logic start;       // request accepted in idle
  logic beat_hs;     // one beat moves this cycle
  logic wr_done;
  logic rd_done;
  logic burst_done;

  assign start      = (state == BR_IDLE) && i_cache_axi_req;
  assign beat_hs    = o_axi_io_valid && i_axi_io_ready;
  assign burst_done = (op_q == REQ_WRITE) ? wr_done : rd_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BR_IDLE;
    end else begin
      case (state)
        BR_IDLE:  if (i_cache_axi_req) state <= BR_BURST;
        BR_BURST: if (burst_done) state <= BR_ACK;
        default:  state <= BR_IDLE;   // ack lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= i_cache_axi_op;
      addr_q <= i_cache_axi_addr;
    end
  end

  axi_write_serializer u_wr_ser (
    .clk          (clk),
    .rst          (rst),
    .i_load       (start && (i_cache_axi_op == REQ_WRITE)),
    .i_line       (i_cache_axi_wdata),
    .i_beat_taken (beat_hs && (op_q == REQ_WRITE)),
    .o_beat       (o_axi_io_wdata),
    .o_done       (wr_done)
  );

  axi_read_assembler u_rd_asm (
    .clk          (clk),
    .rst          (rst),
    .i_start      (start && (i_cache_axi_op == REQ_READ)),
    .i_beat_valid (beat_hs && (op_q == REQ_READ)),
    .i_beat       (i_axi_io_rdata),
    .o_line       (o_cache_axi_rdata),
    .o_done       (rd_done)
  );

  assign o_axi_io_valid  = (state == BR_BURST);
  assign o_axi_io_op     = op_q;
  assign o_axi_io_addr   = addr_q;
  assign o_axi_io_size   = SIZE_DWORD;
  assign o_axi_io_blks   = BLKS;
  assign o_cache_axi_ack = (state == BR_ACK);

  // burst ends only on the eighth beat of the active side
  a_valid_until_done: assert property (
    @(posedge clk) disable iff (rst)
    $fell(o_axi_io_valid) |-> $past(burst_done)
  );

  a_cmd_stable: assert property (
    @(posedge clk) disable iff (rst)
    o_axi_io_valid && $past(o_axi_io_valid) |-> $stable(o_axi_io_addr) && $stable(o_axi_io_op)
  );

endmodule

// File: verilog/line_exerciser.sv
// line exerciser
// writes a pseudo-random line, reads it back, compares and counts results
`timescale 1ns/1ps

module line_exerciser import cache_axi_pkg::*, line_test_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ack,
  input  logic [LINE_W-1:0] i_rdata,
  output logic              o_req,
  output req_op_e           o_op,
  output logic [ADDR_W-1:0] o_addr,
  output logic [LINE_W-1:0] o_wdata,
  output logic [15:0]       o_pass_cnt,
  output logic              o_fail,
  output logic [ADDR_W-1:0] o_fail_addr
);

  test_state_e           state;
  logic [IDLE_CNT_W-1:0] idle_cnt;
  logic [63:0]           lfsr;
  logic [63:0]           lfsr_next;
  logic [LINE_W-1:0]     wdata_q;      // pattern written, kept for the compare
  logic                  line_match;
  logic                  idle_over;

  assign lfsr_next  = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 64'd0);
  assign line_match = (i_rdata == wdata_q);
  assign idle_over  = (idle_cnt == IDLE_CNT_W'(IDLE_CYCLES));

  assign o_req   = (state == ST_WRITE) || (state == ST_READ);
  assign o_op    = ((state == ST_WAIT_WR) || (state == ST_WRITE)) ? REQ_WRITE : REQ_READ;
  assign o_wdata = wdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_WAIT_WR;
      idle_cnt    <= '0;
      lfsr        <= PATTERN_SEED;
      o_addr      <= START_ADDR;
      o_pass_cnt  <= '0;
      o_fail      <= 1'b0;
      o_fail_addr <= '0;
    end else begin
      case (state)
        ST_WAIT_WR: begin
          idle_cnt <= idle_cnt + 1'b1;
          if (idle_cnt < IDLE_CNT_W'(BEATS)) lfsr <= lfsr_next;  // one step per beat
          if (idle_over) begin
            idle_cnt <= '0;
            state    <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (i_ack) state <= ST_WAIT_RD;
        end
        ST_WAIT_RD: begin
          idle_cnt <= idle_cnt + 1'b1;
          if (idle_over) begin
            idle_cnt <= '0;
            state    <= ST_READ;
          end
        end
        default: begin    // ST_READ
          if (i_ack) begin
            state  <= ST_WAIT_WR;
            o_addr <= o_addr + ADDR_W'(LINE_BYTES);
            if (line_match) begin
              o_pass_cnt <= o_pass_cnt + 1'b1;
            end else if (!o_fail) begin
              o_fail      <= 1'b1;     // sticky, first address only
              o_fail_addr <= o_addr;
            end
          end
        end
      endcase
    end
  end

  // beats enter at the top, so the first lfsr step ends up in beat 0
  always_ff @(posedge clk) begin
    if ((state == ST_WAIT_WR) && (idle_cnt < IDLE_CNT_W'(BEATS))) begin
      wdata_q <= {lfsr_next, wdata_q[LINE_W-1:BEAT_W]};
    end
  end

  a_req_until_ack: assert property (
    @(posedge clk) disable iff (rst)
    o_req && !i_ack |=> o_req
  );

endmodule

// File: verilog/cache_axi_sys.sv
// cache_axi subsystem top
// line exerciser on the cache side, bridge out to the axi_io memory port
`timescale 1ns/1ps

module cache_axi_sys import cache_axi_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_axi_io_ready,
  input  logic [BEAT_W-1:0] i_axi_io_rdata,
  output logic              o_axi_io_valid,
  output req_op_e           o_axi_io_op,
  output logic [ADDR_W-1:0] o_axi_io_addr,
  output io_size_e          o_axi_io_size,
  output logic [7:0]        o_axi_io_blks,
  output logic [BEAT_W-1:0] o_axi_io_wdata,
  output logic [15:0]       o_pass_cnt,
  output logic              o_fail,
  output logic [ADDR_W-1:0] o_fail_addr
);

  logic              cache_req;
  req_op_e           cache_op;
  logic [ADDR_W-1:0] cache_addr;
  logic [LINE_W-1:0] cache_wdata;
  logic              cache_ack;
  logic [LINE_W-1:0] cache_rdata;

  line_exerciser u_exerciser (
    .clk         (clk),
    .rst         (rst),
    .i_ack       (cache_ack),
    .i_rdata     (cache_rdata),
    .o_req       (cache_req),
    .o_op        (cache_op),
    .o_addr      (cache_addr),
    .o_wdata     (cache_wdata),
    .o_pass_cnt  (o_pass_cnt),
    .o_fail      (o_fail),
    .o_fail_addr (o_fail_addr)
  );

  cache_axi u_cache_axi (
    .clk               (clk),
    .rst               (rst),
    .i_cache_axi_req   (cache_req),
    .i_cache_axi_op    (cache_op),
    .i_cache_axi_addr  (cache_addr),
    .i_cache_axi_wdata (cache_wdata),
    .o_cache_axi_ack   (cache_ack),
    .o_cache_axi_rdata (cache_rdata),
    .i_axi_io_ready    (i_axi_io_ready),
    .i_axi_io_rdata    (i_axi_io_rdata),
    .o_axi_io_valid    (o_axi_io_valid),
    .o_axi_io_op       (o_axi_io_op),
    .o_axi_io_addr     (o_axi_io_addr),
    .o_axi_io_size     (o_axi_io_size),
    .o_axi_io_blks     (o_axi_io_blks),
    .o_axi_io_wdata    (o_axi_io_wdata)
  );

endmodule

// File: sim/cache_axi_sys_tb.sv
// cache_axi_sys testbench
// axi_io memory model with random ready stalls and directed write/read pair tests
`timescale 1ns/1ps

module cache_axi_sys_tb import cache_axi_pkg::*, line_test_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              ready;
  logic [BEAT_W-1:0] rdata;
  logic              o_axi_io_valid;
  req_op_e           o_axi_io_op;
  logic [ADDR_W-1:0] o_axi_io_addr;
  io_size_e          o_axi_io_size;
  logic [7:0]        o_axi_io_blks;
  logic [BEAT_W-1:0] o_axi_io_wdata;
  logic [15:0]       o_pass_cnt;
  logic              o_fail;
  logic [ADDR_W-1:0] o_fail_addr;

  logic [63:0] mem [logic [63:0]];   // beats keyed by byte address
  logic [15:0] lfsr_q;
  logic [15:0] pass_exp;             // pairs expected to have passed so far

  cache_axi_sys cache_axi_sys_i (
    .clk            (clk),
    .rst            (rst),
    .i_axi_io_ready (ready),
    .i_axi_io_rdata (rdata),
    .o_axi_io_valid (o_axi_io_valid),
    .o_axi_io_op    (o_axi_io_op),
    .o_axi_io_addr  (o_axi_io_addr),
    .o_axi_io_size  (o_axi_io_size),
    .o_axi_io_blks  (o_axi_io_blks),
    .o_axi_io_wdata (o_axi_io_wdata),
    .o_pass_cnt     (o_pass_cnt),
    .o_fail         (o_fail),
    .o_fail_addr    (o_fail_addr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (out ? 16'hb400 : 16'h0000);
    return out;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic wait_valid();
    int cycles;
    cycles = 0;
    while (!o_axi_io_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > 200) stop_run("valid never rose for the next burst");
    end
  endtask

  // serves one burst and corrupts read beat flip_beat when it is not negative
  task automatic serve_burst(input bit stalls, input int flip_beat,
                             output logic [63:0] addr, output req_op_e op);
    int          beat;
    int          cycles;
    logic [63:0] key;
    beat   = 0;
    cycles = 0;
    wait_valid();
    addr = o_axi_io_addr;
    op   = o_axi_io_op;
    check("o_axi_io_size", o_axi_io_size, SIZE_DWORD);
    check("o_axi_io_blks", o_axi_io_blks, 8'd7);
    while (beat < BEATS) begin
      check("o_axi_io_valid", o_axi_io_valid, 1'b1);
      check("o_axi_io_addr", o_axi_io_addr, addr);   // held through stalls
      check("o_axi_io_op", o_axi_io_op, op);
      ready = stalls ? lfsr_bit() : 1'b1;
      key   = addr + 64'(8 * beat);
      if (ready) begin
        if (op == REQ_WRITE) begin
          mem[key] = o_axi_io_wdata;
        end else begin
          if (!mem.exists(key)) stop_run("read of a beat that was never written");
          rdata = mem[key];
          if (beat == flip_beat) rdata = rdata ^ (64'd1 << 17);
        end
        beat++;
      end
      cycles++;
      if (cycles > 200) stop_run("burst did not finish in time");
      @(negedge clk);
    end
    ready = 1'b0;
    check("o_axi_io_valid", o_axi_io_valid, 1'b0);   // drops after beat eight
  endtask

  task automatic wait_result(input logic [15:0] prev_cnt, input logic prev_fail);
    int cycles;
    cycles = 0;
    while (o_pass_cnt == prev_cnt && o_fail == prev_fail) begin
      @(negedge clk);
      cycles++;
      if (cycles > 200) stop_run("no compare result after the read");
    end
  endtask

  task automatic run_pair(input int n, input bit stalls, input int flip_beat);
    logic [63:0] exp_addr;
    logic [63:0] addr;
    req_op_e     op;
    exp_addr = START_ADDR + 64'(LINE_BYTES * n);
    serve_burst(stalls, -1, addr, op);
    check("write o_axi_io_op", op, REQ_WRITE);
    check("write o_axi_io_addr", addr, exp_addr);
    serve_burst(stalls, flip_beat, addr, op);
    check("read o_axi_io_op", op, REQ_READ);
    check("read o_axi_io_addr", addr, exp_addr);
    wait_result(pass_exp, o_fail);
    if (flip_beat < 0) begin
      pass_exp = pass_exp + 16'd1;
      check("o_pass_cnt", o_pass_cnt, pass_exp);
      check("o_fail", o_fail, 1'b0);
    end else begin
      check("o_fail", o_fail, 1'b1);
      check("o_fail_addr", o_fail_addr, exp_addr);
      check("o_pass_cnt", o_pass_cnt, pass_exp);   // no credit for a bad pair
    end
  endtask

  task automatic reset_quiet();
    rst = 1'b1;
    repeat (16) begin
      @(negedge clk);
      check("o_axi_io_valid", o_axi_io_valid, 1'b0);
      check("o_pass_cnt", o_pass_cnt, 16'd0);
      check("o_fail", o_fail, 1'b0);
    end
    rst = 1'b0;
    // first valid comes IDLE_CYCLES+2 cycles after release
    repeat (IDLE_CYCLES + 1) begin
      @(negedge clk);
      check("o_axi_io_valid", o_axi_io_valid, 1'b0);
      check("o_pass_cnt", o_pass_cnt, 16'd0);
      check("o_fail", o_fail, 1'b0);
    end
    @(negedge clk);
    check("o_axi_io_valid", o_axi_io_valid, 1'b1);
  endtask

  task automatic six_pairs();
    bit differs;
    differs = 1'b0;
    run_pair(0, 1'b0, -1);
    for (int n = 1; n < 6; n++) run_pair(n, 1'b0, -1);
    for (int b = 0; b < BEATS; b++) begin
      if (mem[START_ADDR + 64'(8 * b)] != mem[START_ADDR + 64'(LINE_BYTES + 8 * b)]) begin
        differs = 1'b1;
      end
    end
    if (!differs) stop_run("second write line repeats the first");
  endtask

  task automatic stalled_pairs();
    for (int n = 6; n < 9; n++) run_pair(n, 1'b1, -1);
  endtask

  task automatic corrupt_read();
    run_pair(9, 1'b1, 3);
  endtask

  initial begin
    rst      = 1'b1;
    ready    = 1'b0;
    rdata    = '0;
    lfsr_q   = 16'd25403;
    pass_exp = '0;
    reset_quiet();
    six_pairs();
    stalled_pairs();
    corrupt_read();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: cache_axi_sys.f
verilog/cache_axi_pkg.sv
verilog/line_test_pkg.sv
verilog/axi_write_serializer.sv
verilog/axi_read_assembler.sv
verilog/cache_axi.sv
verilog/line_exerciser.sv
verilog/cache_axi_sys.sv
sim/cache_axi_sys_tb.sv
